// File: Bender.yml
package:
  name: cpu16

sources:
  # Design, in compile order
  - hdl/cpuPkg.sv
  - hdl/bypassIf.sv
  - hdl/fetchStage.sv
  - hdl/regFile.sv
  - hdl/decodeStage.sv
  - hdl/executeStage.sv
  - hdl/memoryStage.sv
  - hdl/cpuTop.sv

  # Testbench
  - target: test
    files:
      - tests/tbClock.sv
      - tests/cpuTb.sv

// File: hdl/bypassIf.sv
interface bypassIf import cpuPkg::*; ();

  // EX/MEM source, only set when the result is ready in that stage
  logic    exMemRegWrite;
  regAddrT exMemRd;
  wordT    exMemResult;

  // MEM/WB source, same strobe that writes the register file
  logic    wbEn;
  regAddrT wbReg;
  wordT    wbData;

  modport source (
    output exMemRegWrite, exMemRd, exMemResult,
    output wbEn, wbReg, wbData
  );

  modport sink (
    input exMemRegWrite, exMemRd, exMemResult,
    input wbEn, wbReg, wbData
  );

endinterface

// File: hdl/cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int DataWidth     = 16;   // Datapath and instruction word
  localparam int RegAddrWidth  = 4;
  localparam int NumRegs       = 16;   // r0 is hardwired to zero
  localparam int DataMemDepth  = 256;  // Words of data memory
  localparam int DataAddrWidth = 8;
  localparam int PcStep        = 2;    // Byte addressed, one word per instruction
  localparam int ResetPc       = 0;

  typedef logic [DataWidth-1:0]    wordT;
  typedef logic [RegAddrWidth-1:0] regAddrT;

  // Lives in instr[15:12]
  // Codes that are not listed fall through decode as no-ops
  typedef enum logic [3:0] {
    OpAdd = 4'd0,
    OpSub = 4'd1,
    OpXor = 4'd2,
    OpSll = 4'd4,   // Shift amount is imm4
    OpSra = 4'd5,
    OpLw  = 4'd8,   // Address is rs + sext(imm4)
    OpSw  = 4'd9,   // Stores the value of rd
    OpLlb = 4'd10,  // Low byte of rd from imm8
    OpLhb = 4'd11,  // High byte of rd from imm8
    OpHlt = 4'd15
  } opcodeT;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    wordT pc;     // Address of the fetched word
    wordT instr;
    logic valid;
  } ifIdT;

  typedef struct packed {
    logic    valid;
    opcodeT  op;
    regAddrT rd;
    regAddrT srcA;      // Zero when the operand is not read
    regAddrT srcB;
    wordT    valA;      // Register file values, may be stale
    wordT    valB;
    wordT    imm;       // Already extended
    logic    regWrite;  // Never set for rd == 0
    logic    memRead;
    logic    memWrite;
    logic    halt;
  } idExT;

  typedef struct packed {
    logic    valid;
    wordT    result;     // ALU result or data address
    wordT    storeData;
    regAddrT storeSrc;   // Register that supplied storeData
    regAddrT rd;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;
  } exMemT;

endpackage

// File: hdl/cpuTop.sv
module cpuTop import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  wordT    instr,    // Instruction memory read at pc
  output wordT    pc,
  output logic    hlt,
  output logic    wbEn,     // Write-back trace
  output regAddrT wbReg,
  output wordT    wbData
);

  ifIdT  ifId;
  idExT  idEx;
  exMemT exMem;
  logic  stall;
  logic  haltSeen;

  bypassIf bypass ();

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////////////////////
  fetchStage iFetch (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .haltSeen (haltSeen),
    .instr    (instr),
    .pc       (pc),
    .ifId     (ifId)
  );

  decodeStage iDecode (
    .clk      (clk),
    .rstN     (rstN),
    .ifId     (ifId),
    .wbEn     (bypass.wbEn),
    .wbReg    (bypass.wbReg),
    .wbData   (bypass.wbData),
    .idEx     (idEx),
    .stall    (stall),
    .haltSeen (haltSeen)
  );

  executeStage iExecute (.clk(clk), .rstN(rstN), .idEx(idEx), .bypass(bypass), .exMem(exMem));

  memoryStage iMemory (.clk(clk), .rstN(rstN), .exMem(exMem), .bypass(bypass), .hlt(hlt));

  // Trace mirrors the register file write
  assign wbEn   = bypass.wbEn;
  assign wbReg  = bypass.wbReg;
  assign wbData = bypass.wbData;

endmodule

// File: hdl/decodeStage.sv
module decodeStage import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  ifIdT    ifId,
  input  logic    wbEn,      // Write-back from MEM/WB
  input  regAddrT wbReg,
  input  wordT    wbData,
  output idExT    idEx,
  output logic    stall,     // Load-use bubble
  output logic    haltSeen   // Sticky until reset
);

  opcodeT  op;
  regAddrT rdField;
  regAddrT rsField;
  regAddrT rtField;
  regAddrT srcA;
  regAddrT srcB;
  wordT    valA;
  wordT    valB;
  wordT    imm;
  logic    writesReg;
  logic    memRead;
  logic    memWrite;
  logic    isHalt;
  logic    haltLatched;
  logic    issue;         // A real instruction moves into ID/EX

  // Field split
  assign op      = opcodeT'(ifId.instr[15:12]);
  assign rdField = ifId.instr[11:8];
  assign rsField = ifId.instr[7:4];
  assign rtField = ifId.instr[3:0];

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    srcA      = '0;  // Unused sources stay r0 so they never match a hazard
    srcB      = '0;
    imm       = '0;
    writesReg = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    isHalt    = 1'b0;
    case (op)
      OpAdd, OpSub, OpXor: begin
        srcA      = rsField;
        srcB      = rtField;
        writesReg = 1'b1;
      end
      OpSll, OpSra: begin
        srcA      = rsField;
        imm       = wordT'(ifId.instr[3:0]);  // Shift amount
        writesReg = 1'b1;
      end
      OpLw: begin
        srcA      = rsField;
        imm       = wordT'($signed(ifId.instr[3:0]));
        writesReg = 1'b1;
        memRead   = 1'b1;
      end
      OpSw: begin
        srcA     = rsField;
        srcB     = rdField;                   // Store data comes from rd
        imm      = wordT'($signed(ifId.instr[3:0]));
        memWrite = 1'b1;
      end
      OpLlb, OpLhb: begin
        srcA      = rdField;                  // Keeps the other byte of rd
        imm       = wordT'(ifId.instr[7:0]);
        writesReg = 1'b1;
      end
      OpHlt:   isHalt = 1'b1;
      default: ;                              // No-op
    endcase
  end

  regFile iRegFile (
    .clk       (clk),
    .rstN      (rstN),
    .readAddrA (srcA),
    .readAddrB (srcB),
    .readDataA (valA),
    .readDataB (valB),
    .writeEn   (wbEn),
    .writeAddr (wbReg),
    .writeData (wbData)
  );

  // Load in ID/EX feeding an operand of this instruction
  // SW store data is exempt since the memory stage patches it from MEM/WB
  assign stall = ifId.valid && idEx.valid && idEx.memRead && idEx.regWrite &&
                 ((srcA == idEx.rd) || (!memWrite && srcB == idEx.rd));

  assign issue    = ifId.valid && !stall;
  assign haltSeen = haltLatched || (ifId.valid && isHalt);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      haltLatched <= 1'b0;
    end else if (ifId.valid && isHalt) begin
      haltLatched <= 1'b1;
    end
  end

  // ID/EX register, controls cleared for a bubble
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= '0;
    end else begin
      idEx <= '{valid: issue, op: op, rd: rdField, srcA: srcA, srcB: srcB,
                valA: valA, valB: valB, imm: imm,
                regWrite: issue && writesReg && (rdField != '0),
                memRead: issue && memRead, memWrite: issue && memWrite,
                halt: issue && isHalt};
    end
  end

  // One bubble per load, and HLT never waits behind one
  assert property (@(posedge clk) disable iff (!rstN) stall |=> !(stall || haltSeen));

  // Fetch keeps the stalled word in IF/ID
  assert property (@(posedge clk) disable iff (!rstN)
                   stall |=> ifId.valid && $stable(ifId.pc));

endmodule

// File: hdl/executeStage.sv
module executeStage import cpuPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  idExT         idEx,
  bypassIf.sink        bypass,
  output exMemT        exMem
);

  logic fwdExA;     // Operand A from EX/MEM
  logic fwdExB;
  logic fwdWbA;     // Operand A from MEM/WB
  logic fwdWbB;
  wordT opA;
  wordT opB;        // Also the store data
  wordT aluResult;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding, youngest producer first
  ////////////////////////////////////////////////////////////////////////////
  assign fwdExA = bypass.exMemRegWrite && (idEx.srcA != '0) && (bypass.exMemRd == idEx.srcA);
  assign fwdExB = bypass.exMemRegWrite && (idEx.srcB != '0) && (bypass.exMemRd == idEx.srcB);
  assign fwdWbA = bypass.wbEn && (idEx.srcA != '0) && (bypass.wbReg == idEx.srcA);
  assign fwdWbB = bypass.wbEn && (idEx.srcB != '0) && (bypass.wbReg == idEx.srcB);

  assign opA = fwdExA ? bypass.exMemResult :
               fwdWbA ? bypass.wbData      : idEx.valA;
  assign opB = fwdExB ? bypass.exMemResult :
               fwdWbB ? bypass.wbData      : idEx.valB;

  // ALU, also forms the data address for LW and SW
  always_comb begin
    case (idEx.op)
      OpAdd:       aluResult = opA + opB;               // Wraps
      OpSub:       aluResult = opA - opB;
      OpXor:       aluResult = opA ^ opB;
      OpSll:       aluResult = opA << idEx.imm[3:0];
      OpSra:       aluResult = wordT'($signed(opA) >>> idEx.imm[3:0]);
      OpLw, OpSw:  aluResult = opA + idEx.imm;
      OpLlb:       aluResult = {opA[DataWidth-1:8], idEx.imm[7:0]};
      OpLhb:       aluResult = {idEx.imm[7:0], opA[7:0]};
      default:     aluResult = '0;
    endcase
  end

  // EX/MEM register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else begin
      exMem <= '{valid: idEx.valid, result: aluResult, storeData: opB,
                 storeSrc: idEx.srcB, rd: idEx.rd, regWrite: idEx.regWrite,
                 memRead: idEx.memRead, memWrite: idEx.memWrite,
                 halt: idEx.halt};
    end
  end

  // The memory stage hides loads from the EX/MEM bypass
  assert property (@(posedge clk) disable iff (!rstN)
                   (fwdExA || fwdExB) |-> !$past(idEx.valid && idEx.memRead));

endmodule

// File: hdl/fetchStage.sv
module fetchStage import cpuPkg::*; (
  input  logic clk,
  input  logic rstN,
  input  logic stall,     // Load-use hold from decode
  input  logic haltSeen,  // HLT is in decode or already past it
  input  wordT instr,     // Instruction memory answers at pc in the same cycle
  output wordT pc,
  output ifIdT ifId
);

  logic advance;

  assign advance = !stall && !haltSeen;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= wordT'(ResetPc);
    end else if (advance) begin
      pc <= pc + wordT'(PcStep);  // Frozen at HLT + PcStep once halted
    end
  end

  // IF/ID register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ifId <= '0;
    end else if (haltSeen) begin
      ifId.valid <= 1'b0;  // Word fetched behind HLT is dropped
    end else if (!stall) begin
      ifId <= '{pc: pc, instr: instr, valid: 1'b1};
    end
  end

  // The stalled instruction must be refetched from the same address
  assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(pc));

endmodule

// File: hdl/memoryStage.sv
module memoryStage import cpuPkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  exMemT        exMem,
  bypassIf.source      bypass,
  output logic         hlt      // Sticky once HLT reaches MEM/WB
);

  wordT                     dataMem [DataMemDepth];
  logic [DataAddrWidth-1:0] memAddr;
  wordT                     loadData;   // Asynchronous read
  wordT                     storeData;
  logic                     storeFwd;

  // MEM/WB register
  logic    wbRegWrite;
  logic    wbMemRead;   // Select loaded word for write-back
  regAddrT wbRd;
  wordT    wbResult;
  wordT    wbLoad;

  assign memAddr  = exMem.result[DataAddrWidth-1:0];
  assign loadData = dataMem[memAddr];

  // SW right behind the load or ALU op that produced its data
  assign storeFwd  = bypass.wbEn && (bypass.wbReg == exMem.storeSrc);
  assign storeData = storeFwd ? bypass.wbData : exMem.storeData;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      dataMem <= '{default: '0};
    end else if (exMem.valid && exMem.memWrite) begin
      dataMem[memAddr] <= storeData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbRegWrite <= 1'b0;
      wbMemRead  <= 1'b0;
      hlt        <= 1'b0;
    end else begin
      wbRegWrite <= exMem.valid && exMem.regWrite;
      wbMemRead  <= exMem.memRead;
      if (exMem.valid && exMem.halt) hlt <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    wbRd     <= exMem.rd;
    wbResult <= exMem.result;
    wbLoad   <= loadData;
  end

  // A load result is not ready in EX/MEM, so it is not offered there
  assign bypass.exMemRegWrite = exMem.valid && exMem.regWrite && !exMem.memRead;
  assign bypass.exMemRd       = exMem.rd;
  assign bypass.exMemResult   = exMem.result;

  assign bypass.wbEn   = wbRegWrite;
  assign bypass.wbReg  = wbRd;
  assign bypass.wbData = wbMemRead ? wbLoad : wbResult;

  // Decode drops regWrite for rd == 0
  assert property (@(posedge clk) disable iff (!rstN) bypass.wbEn |-> bypass.wbReg != '0);

endmodule

// File: hdl/regFile.sv
module regFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regAddrT readAddrA,
  input  regAddrT readAddrB,
  output wordT    readDataA,
  output wordT    readDataB,
  input  logic    writeEn,
  input  regAddrT writeAddr,
  input  wordT    writeData
);

  wordT regs [NumRegs];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (writeEn && writeAddr != '0) begin
      regs[writeAddr] <= writeData;  // r0 is never written
    end
  end

  // Write-back in the same cycle wins over the stored word
  assign readDataA = (readAddrA == '0)                       ? '0        :
                     (writeEn && writeAddr == readAddrA)     ? writeData :
                                                               regs[readAddrA];

  assign readDataB = (readAddrB == '0)                       ? '0        :
                     (writeEn && writeAddr == readAddrB)     ? writeData :
                                                               regs[readAddrB];

endmodule

// File: project.f
hdl/cpuPkg.sv
hdl/bypassIf.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
tests/tbClock.sv
tests/cpuTb.sv

// File: tests/cpuTb.sv
module cpuTb import cpuPkg::*; ();

  localparam int Seed         = 63334;
  localparam int BodyLen      = 40;   // Instructions before HLT
  localparam int ResetCycles  = 3;
  localparam int HaltTimeout  = 400;  // Cycles allowed until hlt
  localparam int DrainCycles  = 12;   // Quiet window after hlt

  logic    clk;
  logic    rstN;
  wordT    instr;
  wordT    pc;
  logic    hlt;
  logic    wbEn;
  regAddrT wbReg;
  wordT    wbData;

  wordT    prog [$];     // Instruction memory image
  regAddrT expReg [$];   // Expected write-back trace
  wordT    expData [$];
  wordT    expPc;
  int      expIdx;
  int      errors;
  bit      hltLogged;

  tbClock #(.Period(20)) clockGen (.clk(clk));

  cpuTop uut (
    .clk    (clk),
    .rstN   (rstN),
    .instr  (instr),
    .pc     (pc),
    .hlt    (hlt),
    .wbEn   (wbEn),
    .wbReg  (wbReg),
    .wbData (wbData)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Program building
  ////////////////////////////////////////////////////////////////////////////
  function automatic wordT encode(input opcodeT op, input regAddrT rd,
                                  input regAddrT rs, input logic [3:0] low);
    return {op, rd, rs, low};
  endfunction

  function automatic wordT encodeImm8(input opcodeT op, input regAddrT rd,
                                      input logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  function automatic regAddrT pickReg();
    return regAddrT'($urandom_range(0, 5));  // Small set that includes r0
  endfunction

  task automatic emit(input wordT w);
    if (prog.size() < BodyLen) prog.push_back(w);  // Patterns get cut at the end
  endtask

  task automatic buildProgram();
    regAddrT    a;
    regAddrT    b;
    regAddrT    c;
    logic [3:0] off;
    opcodeT     op;
    int         kind;
    int         r;
    prog.delete();
    for (r = 1; r <= 5; r++) begin
      emit(encodeImm8(OpLlb, regAddrT'(r), 8'($urandom)));
      emit(encodeImm8(OpLhb, regAddrT'(r), 8'($urandom)));
    end
    while (prog.size() < BodyLen) begin
      kind = $urandom_range(0, 7);
      a    = pickReg();
      b    = pickReg();
      c    = pickReg();
      off  = 4'($urandom);
      case ($urandom_range(0, 2))
        0:       op = OpAdd;
        1:       op = OpSub;
        default: op = OpXor;
      endcase
      case (kind)
        0: emit(encode(op, a, b, c));
        1: emit(encode(($urandom_range(0, 1) != 0) ? OpSll : OpSra, a, b, 4'($urandom)));
        2: emit(encodeImm8(($urandom_range(0, 1) != 0) ? OpLlb : OpLhb, a, 8'($urandom)));
        3: begin
          emit(encode(OpSw, a, b, off));    // Store and load it back at once
          emit(encode(OpLw, c, b, off));
          emit(encode(OpAdd, pickReg(), c, c));  // Load-use
        end
        4: begin
          emit(encode(op, a, b, c));         // ALU result is address and data
          emit(encode(OpSw, a, a, off));
          emit(encode(OpLw, b, a, off));
        end
        5: begin
          emit(encode(OpLw, a, b, off));
          emit(encode(OpSw, a, c, off));     // Stores the value just loaded
          emit(encode(OpLw, b, c, off));
        end
        6: begin
          emit(encode(OpXor, a, b, c));      // Chain through both bypasses
          emit(encode(OpSub, b, a, c));
          emit(encode(OpAdd, c, b, a));
        end
        default: emit({4'd12, 12'($urandom)});  // Unused opcode
      endcase
    end
    prog.push_back({OpHlt, 12'h000});
  endtask

  // Word at pc
  // Past the program a word that would write r15 if it issued
  function automatic wordT fetchWord(input wordT addr);
    logic [14:0] idx;
    idx = addr[15:1];
    if (addr[0] == 1'b0 && idx < prog.size()) return prog[idx];
    return {OpLlb, 4'hF, idx[7:0] ^ {addr[0], idx[14:8]}};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model with in-order ISA semantics
  ////////////////////////////////////////////////////////////////////////////
  function automatic wordT runReference();
    wordT                     regs [NumRegs];
    wordT                     mem [DataMemDepth];
    wordT                     w;
    wordT                     valS;
    wordT                     valT;
    wordT                     valD;
    wordT                     off;
    wordT                     sum;
    wordT                     res;
    regAddrT                  rd;
    logic [DataAddrWidth-1:0] addr;
    logic                     writes;
    int                       i;
    regs = '{default: '0};
    mem  = '{default: '0};
    expReg.delete();
    expData.delete();
    for (i = 0; i < prog.size(); i++) begin
      w      = prog[i];
      rd     = w[11:8];
      valS   = regs[w[7:4]];
      valT   = regs[w[3:0]];
      valD   = regs[rd];                    // Source for LLB, LHB and SW data
      off    = {{12{w[3]}}, w[3:0]};
      sum    = valS + off;
      addr   = sum[DataAddrWidth-1:0];
      writes = 1'b1;
      res    = '0;
      case (w[15:12])
        OpAdd: res = valS + valT;
        OpSub: res = valS - valT;
        OpXor: res = valS ^ valT;
        OpSll: res = valS << w[3:0];
        OpSra: res = $signed(valS) >>> w[3:0];
        OpLw:  res = mem[addr];
        OpLlb: res = {valD[15:8], w[7:0]};
        OpLhb: res = {w[7:0], valD[7:0]};
        OpSw: begin
          mem[addr] = valD;
          writes    = 1'b0;
        end
        OpHlt:   return wordT'(i * PcStep + PcStep);  // pc freezes one word on
        default: writes = 1'b0;
      endcase
      if (writes && rd != '0) begin         // r0 writes are dropped
        regs[rd] = res;
        expReg.push_back(rd);
        expData.push_back(res);
      end
    end
    return '0;
  endfunction

  // Instruction memory answers at the new pc right after each rising edge
  always @(pc) instr <= fetchWord(pc);

  ////////////////////////////////////////////////////////////////////////////
  // Write-back checker that samples on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstN === 1'b1) begin
      if (wbEn !== 1'b0 && wbEn !== 1'b1) begin
        $display("wbEn is unknown after reset");
        errors++;
      end
      if (wbEn === 1'b1) begin
        if (wbReg == '0) begin
          $display("a write to register 0 showed up on the trace");
          errors++;
        end
        if (expIdx >= expReg.size()) begin
          $display("extra write-back to register %0d after the last expected one", wbReg);
          errors++;
        end else begin
          if (wbReg !== expReg[expIdx]) begin
            $display("mismatch wbReg: expected %h, got %h (write-back %0d)",
                     expReg[expIdx], wbReg, expIdx);
            errors++;
          end
          if (wbData !== expData[expIdx]) begin
            $display("mismatch wbData: expected %h, got %h (write-back %0d)",
                     expData[expIdx], wbData, expIdx);
            errors++;
          end
          expIdx++;
        end
      end
      if (hltLogged && hlt !== 1'b1) begin
        $display("hlt dropped after it had risen");
        errors++;
      end
      if (hlt === 1'b1 && !hltLogged) begin
        hltLogged = 1'b1;
        if (expIdx != expReg.size()) begin
          $display("hlt rose with %0d write-backs still missing", expReg.size() - expIdx);
          errors++;
        end
      end
    end
  end

  initial begin
    int cycles;
    int seedDummy;
    rstN      = 1'b0;
    instr     = '0;
    expIdx    = 0;
    errors    = 0;
    hltLogged = 1'b0;
    seedDummy = $urandom(Seed);
    buildProgram();
    expPc = runReference();
    $display("program of %0d words, %0d write-backs expected", prog.size(), expReg.size());

    // Outputs must sit low while reset is held
    repeat (ResetCycles - 1) begin
      @(posedge clk);
      @(negedge clk);
      if (wbEn !== 1'b0 || hlt !== 1'b0) begin
        $display("wbEn or hlt is not low during reset");
        errors++;
      end
    end
    @(posedge clk);
    rstN <= 1'b1;

    cycles = 0;
    while (hlt !== 1'b1 && cycles < HaltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (hlt !== 1'b1) begin
      $display("timeout, hlt did not rise within %0d cycles", HaltTimeout);
      errors++;
    end else begin
      cycles = 0;
      while (cycles < DrainCycles) begin   // No write-back may follow hlt
        @(negedge clk);
        cycles++;
      end
      if (pc !== expPc) begin
        $display("mismatch pc: expected %h, got %h", expPc, pc);
        errors++;
      end
      if (expIdx != expReg.size()) begin
        $display("only %0d of %0d expected write-backs appeared", expIdx, expReg.size());
        errors++;
      end
    end

    // Checker is done with the last falling edge by the next rising one
    @(posedge clk);
    $display("%0d errors, %0d of %0d write-backs compared", errors, expIdx, expReg.size());
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tests/tbClock.sv
module tbClock #(
  parameter int Period = 20
) (
  output logic clk
);

  // Low at start, first rising edge half a period in
  initial clk = 1'b0;

  always #(Period / 2) clk = ~clk;

endmodule
